// File: Makefile
SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert -Wall
TOP       := tb_fetch_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIMFLAGS  := +verilator+error+limit+1000
PASS_MSG  := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: common/fetch_pkg.sv
package fetch_pkg;

    // Instruction word width
    localparam int INSTR_W = 32;

    // Number of words in the instruction RAM
    localparam int IMEM_DEPTH = 16;

    // Word index width, follows the depth
    localparam int ADDR_W = $clog2(IMEM_DEPTH);

    // One instruction word
    typedef logic [INSTR_W-1:0] instr_t;

    // Word address, used for PC, jump target and load address
    typedef logic [ADDR_W-1:0] pc_t;

    // Fetch unit control states
    typedef enum logic [1:0] {
        FS_IDLE = 2'd0,  // Out of reset, nothing issued yet
        FS_RUN  = 2'd1,  // Last cycle issued a read
        FS_HOLD = 2'd2   // Last cycle stalled or lost the port
    } fetch_state_t;

endpackage

// File: common/imem_if.sv
`timescale 1ns/1ps

interface imem_if;
    import fetch_pkg::*;

    logic   req;     // Requester wants the port
    logic   we;      // Write when set, read otherwise
    pc_t    addr;    // Word address
    instr_t wdata;   // Write data
    logic   gnt;     // Port taken this cycle
    logic   rvalid;  // Read data present, one cycle after a granted read
    instr_t rdata;   // Read data

    // Side that asks for the memory
    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    // Side that owns the memory
    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

// File: fetch/instruction_fetch.sv
`timescale 1ns/1ps

module instruction_fetch (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_stall,        // Hold the PC
    input  logic              i_jump,         // Take the jump target on issue
    input  fetch_pkg::pc_t    i_jump_target,  // Jump destination
    imem_if.requester         mem,            // Memory port toward arbiter
    output fetch_pkg::instr_t o_instr,        // Returned word
    output fetch_pkg::pc_t    o_instr_pc,     // PC of the returned word
    output logic              o_instr_valid,  // Returned word present
    output fetch_pkg::pc_t    o_link          // Return address of that word
);
    import fetch_pkg::*;

    fetch_state_t state_q;    // Control state
    fetch_state_t state_d;
    pc_t          pc_q;       // Program counter
    pc_t          pc_next;    // PC after an issue
    pc_t          issued_q;   // PC of the read in flight

    logic active;  // Out of idle and not stalled
    logic issue;   // Read taken by the arbiter this cycle

    // Next word index, wraps at the top of memory
    function automatic pc_t pc_inc(input pc_t pc);
        pc_t res;
        if (pc == pc_t'(IMEM_DEPTH - 1)) begin
            res = '0;  // Wrap to word 0
        end else begin
            res = pc + pc_t'(1);
        end
        return res;
    endfunction

    // A held or lost request stays up until taken
    assign active = (state_q != FS_IDLE) & ~i_stall;
    assign issue  = active & mem.gnt;  // Only counts with the grant

    // Jump only matters when issuing
    assign pc_next = i_jump ? i_jump_target : pc_inc(pc_q);

    // State transitions
    always_comb begin
        state_d = state_q;
        case (state_q)
            FS_IDLE: state_d = FS_RUN;               // Start one cycle after reset
            FS_RUN:  state_d = issue ? FS_RUN : FS_HOLD;
            FS_HOLD: state_d = issue ? FS_RUN : FS_HOLD;
            default: state_d = FS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FS_IDLE;
            pc_q    <= '0;       // First issue is word 0
        end else begin
            state_q <= state_d;
            if (issue) begin
                pc_q <= pc_next;  // Advance only on a taken read
            end
        end
    end

    // Tag for the word coming back next cycle
    always_ff @(posedge clk) begin
        if (issue) begin
            issued_q <= pc_q;
        end
    end

    // Read-only requester
    assign mem.req   = active;
    assign mem.we    = 1'b0;
    assign mem.addr  = pc_q;
    assign mem.wdata = '0;

    // Return path, valid straight from the arbiter
    assign o_instr_valid = mem.rvalid;
    assign o_instr       = mem.rdata;
    assign o_instr_pc    = issued_q;
    assign o_link        = pc_inc(issued_q);  // PC plus one, mod depth

endmodule

// File: source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_stall,        // Pipeline stall
    input  logic              i_jump,         // Jump strobe
    input  fetch_pkg::pc_t    i_jump_target,  // Jump destination
    input  logic              i_load_we,      // Program load strobe
    input  fetch_pkg::pc_t    i_load_addr,    // Program load word index
    input  fetch_pkg::instr_t i_load_data,    // Program load word
    output logic              o_load_busy,    // Load entry pending
    output fetch_pkg::instr_t o_instr,        // Fetched word
    output fetch_pkg::pc_t    o_instr_pc,     // PC of fetched word
    output logic              o_instr_valid,  // Fetched word present
    output fetch_pkg::pc_t    o_link          // PC plus one of fetched word
);
    import fetch_pkg::*;

    imem_if ld_if ();  // Loader to arbiter
    imem_if fe_if ();  // Fetch to arbiter

    logic   mem_we;
    pc_t    mem_addr;
    instr_t mem_wdata;
    instr_t mem_rdata;

    prog_loader u_loader (
        .clk         (clk),
        .rst         (rst),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_busy      (o_load_busy),
        .mem         (ld_if.requester)
    );

    instruction_fetch u_fetch (
        .clk           (clk),
        .rst           (rst),
        .i_stall       (i_stall),
        .i_jump        (i_jump),
        .i_jump_target (i_jump_target),
        .mem           (fe_if.requester),
        .o_instr       (o_instr),
        .o_instr_pc    (o_instr_pc),
        .o_instr_valid (o_instr_valid),
        .o_link        (o_link)
    );

    imem_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .ld          (ld_if.arbiter),
        .fe          (fe_if.arbiter),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata)
    );

    instr_mem u_mem (
        .clk     (clk),
        .i_we    (mem_we),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

endmodule

// File: source/imem_arbiter.sv
`timescale 1ns/1ps

module imem_arbiter (
    input  logic              clk,
    input  logic              rst,
    imem_if.arbiter           ld,          // High priority loader port
    imem_if.arbiter           fe,          // Low priority fetch port
    output logic              o_mem_we,    // RAM write strobe
    output fetch_pkg::pc_t    o_mem_addr,  // RAM word index
    output fetch_pkg::instr_t o_mem_wdata, // RAM write data
    input  fetch_pkg::instr_t i_mem_rdata  // RAM registered read data
);

    logic rd_fe_q;  // Fetch read granted last cycle

    // Fixed priority with the loader first
    assign ld.gnt = ld.req;
    assign fe.gnt = fe.req & ~ld.req;  // Fetch only when loader idle

    // Steer the granted requester onto the RAM
    always_comb begin
        if (ld.req) begin
            o_mem_we    = ld.we;
            o_mem_addr  = ld.addr;
            o_mem_wdata = ld.wdata;
        end else begin
            o_mem_we    = fe.req & fe.we;  // No write without a request
            o_mem_addr  = fe.addr;
            o_mem_wdata = fe.wdata;
        end
    end

    // Track whether the word coming out of the RAM next cycle belongs to fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_fe_q <= 1'b0;
        end else begin
            rd_fe_q <= fe.gnt & ~fe.we;  // Granted fetch read
        end
    end

    // Return path lines up with RAM latency
    assign ld.rvalid = 1'b0;  // Loader only writes
    assign ld.rdata  = i_mem_rdata;
    assign fe.rvalid = rd_fe_q;
    assign fe.rdata  = i_mem_rdata;  // Shared read bus

endmodule

// File: source/instr_mem.sv
`timescale 1ns/1ps

module instr_mem (
    input  logic             clk,
    input  logic             i_we,     // Write strobe
    input  fetch_pkg::pc_t   i_addr,   // Word index
    input  fetch_pkg::instr_t i_wdata, // Word to store
    output fetch_pkg::instr_t o_rdata  // Registered read word
);
    import fetch_pkg::*;

    instr_t mem [IMEM_DEPTH];  // 16 x 32 storage
    instr_t rdata_q;           // Read port register

    // Write port
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;  // Store at word index
        end
    end

    // Read port, one cycle of latency
    // Old contents are returned if the same word is written in that cycle
    always_ff @(posedge clk) begin
        rdata_q <= mem[i_addr];  // Sample every cycle
    end

    assign o_rdata = rdata_q;  // Word for the previous address

endmodule

// File: source/prog_loader.sv
`timescale 1ns/1ps

module prog_loader (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_load_we,   // One-cycle load strobe
    input  fetch_pkg::pc_t    i_load_addr, // Target word
    input  fetch_pkg::instr_t i_load_data, // Word to load
    output logic              o_busy,      // Entry pending
    imem_if.requester         mem          // Memory port toward arbiter
);
    import fetch_pkg::*;

    logic   pend_q;  // Buffer holds a write
    pc_t    addr_q;  // Pending word index
    instr_t data_q;  // Pending word

    logic accept;  // Strobe taken into the buffer
    logic done;    // Write handed to the RAM

    // A strobe while busy is dropped
    assign accept = i_load_we & ~pend_q;
    assign done   = pend_q & mem.gnt;  // Counts only with req and gnt

    // Valid bit of the one-entry buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q <= 1'b0;
        end else if (accept) begin
            pend_q <= 1'b1;  // Request from next cycle
        end else if (done) begin
            pend_q <= 1'b0;  // Freed after the write
        end
    end

    // Payload stays put while waiting for a grant
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_load_addr;
            data_q <= i_load_data;
        end
    end

    // Write-only requester
    assign mem.req   = pend_q;
    assign mem.we    = pend_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = data_q;

    assign o_busy = pend_q;  // Busy until the RAM takes it

endmodule

// File: src.f
common/fetch_pkg.sv
common/imem_if.sv
source/instr_mem.sv
source/imem_arbiter.sv
source/prog_loader.sv
fetch/instruction_fetch.sv
source/fetch_top.sv
verif/fetch_asserts.sv
verif/tb_fetch_top.sv

// File: verif/fetch_asserts.sv
`timescale 1ns/1ps

module fetch_asserts (
    input logic           clk,
    input logic           rst,
    input logic           i_stall,
    input logic           i_jump,
    input fetch_pkg::pc_t i_jump_target,
    input logic           o_load_busy,
    input logic           o_instr_valid,
    input fetch_pkg::pc_t o_instr_pc,
    input fetch_pkg::pc_t o_link
);
    import fetch_pkg::*;

    int unsigned n_reset = 0;  // Failures per property
    int unsigned n_busy  = 0;
    int unsigned n_stall = 0;
    int unsigned n_link  = 0;
    int unsigned n_seq   = 0;
    int unsigned n_jump  = 0;
    int unsigned fail_cnt;     // Sum of all failures

    assign fail_cnt = n_reset + n_busy + n_stall + n_link + n_seq + n_jump;

    // Quiet outputs in reset and the cycle after
    reset_quiet: assert property (@(posedge clk) $past(rst) |->
                                  (!o_instr_valid && !o_load_busy))
        else begin
            $error("fetch or loader active around reset");
            n_reset++;
        end

    // No fetch issue while the loader owns the port
    busy_blocks: assert property (@(posedge clk) disable iff (rst)
                                  o_load_busy |=> !o_instr_valid)
        else begin
            $error("word fetched while loader busy");
            n_busy++;
        end

    stall_blocks: assert property (@(posedge clk) disable iff (rst)
                                   i_stall |=> !o_instr_valid)
        else begin
            $error("word fetched during stall");
            n_stall++;
        end

    link_value: assert property (@(posedge clk) disable iff (rst)
                                 o_instr_valid |->
                                 o_link == pc_t'((int'(o_instr_pc) + 1) % IMEM_DEPTH))
        else begin
            $error("link is not pc plus one");
            n_link++;
        end

    // Back to back words without a jump step by one with wrap
    seq_step: assert property (@(posedge clk) disable iff (rst)
                               (o_instr_valid && $past(o_instr_valid) && !$past(i_jump, 2)) |->
                               o_instr_pc == pc_t'((int'($past(o_instr_pc)) + 1) % IMEM_DEPTH))
        else begin
            $error("pc sequence broken");
            n_seq++;
        end

    // Second word after a jump issue comes from the target
    jump_target: assert property (@(posedge clk) disable iff (rst)
                                  (o_instr_valid && $past(o_instr_valid) && $past(i_jump, 2)) |->
                                  o_instr_pc == $past(i_jump_target, 2))
        else begin
            $error("jump target not fetched");
            n_jump++;
        end

endmodule

bind fetch_top fetch_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .i_stall       (i_stall),
    .i_jump        (i_jump),
    .i_jump_target (i_jump_target),
    .o_load_busy   (o_load_busy),
    .o_instr_valid (o_instr_valid),
    .o_instr_pc    (o_instr_pc),
    .o_link        (o_link)
);

// File: verif/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int CLK_NS   = 20;
    localparam int RESET_CY = 5;
    // Cycle budget of each test summed for the watchdog
    localparam int T_RESET  = 20;
    localparam int T_LOAD   = IMEM_DEPTH * 8 + 40;
    localparam int T_SEQ    = 40;
    localparam int T_JUMP   = 4 * 10;
    localparam int T_STALL  = 6 * 10;
    localparam int WDOG_CY  = T_RESET + T_LOAD + T_SEQ + T_JUMP + T_STALL + 100;

    logic   clk;
    logic   rst;
    logic   i_stall;
    logic   i_jump;
    pc_t    i_jump_target;
    logic   i_load_we;
    pc_t    i_load_addr;
    instr_t i_load_data;
    logic   o_load_busy;
    instr_t o_instr;
    pc_t    o_instr_pc;
    logic   o_instr_valid;
    pc_t    o_link;

    integer seed = 32'hbf680c56;  // Fixed seed for load data, jumps and stalls
    instr_t shadow [IMEM_DEPTH];  // Expected memory contents
    logic   loaded [IMEM_DEPTH];  // Word has been written
    pc_t    pend_addr;            // Load handed to the loader
    instr_t pend_data;
    pc_t    exp_pc;               // PC of the next fetched word
    logic   jump_q;               // i_jump seen at the previous edge
    pc_t    target_q;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     jumps_seen = 0;
    int     wraps_seen = 0;
    int     data_seen = 0;
    int     asrt_fails;

    fetch_top u_fetch_top (
        .clk           (clk),
        .rst           (rst),
        .i_stall       (i_stall),
        .i_jump        (i_jump),
        .i_jump_target (i_jump_target),
        .i_load_we     (i_load_we),
        .i_load_addr   (i_load_addr),
        .i_load_data   (i_load_data),
        .o_load_busy   (o_load_busy),
        .o_instr       (o_instr),
        .o_instr_pc    (o_instr_pc),
        .o_instr_valid (o_instr_valid),
        .o_link        (o_link)
    );

    // Word index plus one wrapping back to 0
    function automatic pc_t next_word(input pc_t pc);
        return pc_t'((int'(pc) + 1) % IMEM_DEPTH);
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WDOG_CY * CLK_NS);
        $display("run timed out after %0d cycles", WDOG_CY);
        $display("STATUS: FAIL");
        $finish;
    end

    // Reference model of the fetch stream sampled at each rising edge
    always @(posedge clk) begin
        if (rst) begin
            exp_pc = '0;  // First word after reset is word 0
            jump_q = 1'b0;
            foreach (loaded[i]) loaded[i] = 1'b0;
        end else begin
            if (o_instr_valid) begin
                checks++;
                assert (o_instr_pc == exp_pc) else begin
                    $display("error: %0t ns fetched pc %0d, expected %0d", $time, o_instr_pc,
                             exp_pc);
                    errors++;
                end
                assert (o_link == next_word(o_instr_pc)) else begin
                    $display("error: %0t ns link %0d for pc %0d", $time, o_link, o_instr_pc);
                    errors++;
                end
                if (loaded[o_instr_pc]) begin
                    data_seen++;
                    assert (o_instr == shadow[o_instr_pc]) else begin
                        $display("error: %0t ns word %h at pc %0d, expected %h", $time,
                                 o_instr, o_instr_pc, shadow[o_instr_pc]);
                        errors++;
                    end
                end
                if (jump_q) jumps_seen++;
                if (o_instr_pc == pc_t'(IMEM_DEPTH - 1) && !jump_q) wraps_seen++;
                exp_pc = jump_q ? target_q : next_word(o_instr_pc);  // Jump in issue cycle
            end
            if (o_load_busy) begin  // Loader owns the port and the write lands at this edge
                shadow[pend_addr] = pend_data;
                loaded[pend_addr] = 1'b1;
            end
            jump_q   = i_jump;
            target_q = i_jump_target;
        end
    end

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s finished at %0t ns, errors so far %0d", tests, name, $time,
                 errors);
    endtask

    task automatic wait_valid(input int max_cy);
        int n;
        n = 0;
        @(posedge clk);
        while (!o_instr_valid && n < max_cy) begin
            @(posedge clk);
            n++;
        end
        if (!o_instr_valid) begin
            $display("no fetched word arrived within %0d cycles after reset", max_cy);
            errors++;
        end
    endtask

    task automatic load_word(input pc_t addr, input instr_t data);
        int n;
        n = 0;
        @(posedge clk);
        i_load_we   <= 1'b1;
        i_load_addr <= addr;
        i_load_data <= data;
        pend_addr   <= addr;
        pend_data   <= data;
        @(posedge clk);
        i_load_we <= 1'b0;
        @(posedge clk);  // Busy visible from here
        while (o_load_busy && n < 8) begin
            @(posedge clk);
            n++;
        end
        if (o_load_busy) begin
            $display("loader still busy with word %0d after 8 cycles", addr);
            errors++;
        end
    endtask

    initial begin
        rst           = 1'b1;
        i_stall       = 1'b0;
        i_jump        = 1'b0;
        i_jump_target = '0;
        i_load_we     = 1'b0;
        i_load_addr   = '0;
        i_load_data   = '0;
        pend_addr     = '0;
        pend_data     = '0;
        repeat (RESET_CY) @(posedge clk);
        rst <= 1'b0;
        wait_valid(10);
        end_test("reset");

        for (int a = 0; a < IMEM_DEPTH; a++) begin  // Fetch keeps running meanwhile
            load_word(pc_t'(a), instr_t'($random(seed)));
        end
        repeat (2 * IMEM_DEPTH + 4) @(posedge clk);
        assert (data_seen >= IMEM_DEPTH) else begin
            $display("only %0d loaded words were read back", data_seen);
            errors++;
        end
        end_test("load and read back");

        wraps_seen = 0;  // Count only wraps of the free-running stretch
        repeat (T_SEQ) @(posedge clk);
        assert (wraps_seen > 0) else begin
            $display("the PC never wrapped from the last word");
            errors++;
        end
        end_test("sequence and wrap");

        for (int j = 0; j < 4; j++) begin
            @(posedge clk);
            i_jump        <= 1'b1;  // Running and unstalled so this is an issue cycle
            i_jump_target <= pc_t'($random(seed));
            @(posedge clk);
            i_jump <= 1'b0;
            repeat (4 + $unsigned($random(seed)) % 4) @(posedge clk);
        end
        assert (jumps_seen >= 4) else begin
            $display("only %0d jumps reached the fetched stream", jumps_seen);
            errors++;
        end
        end_test("jump");

        for (int s = 0; s < 6; s++) begin
            @(posedge clk);
            i_stall <= 1'b1;
            repeat (1 + $unsigned($random(seed)) % 4) @(posedge clk);
            i_stall <= 1'b0;
            repeat (3 + $unsigned($random(seed)) % 3) @(posedge clk);
        end
        end_test("stall");

        repeat (4) @(posedge clk);
        asrt_fails = int'(u_fetch_top.u_asserts.fail_cnt);
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", tests, checks,
                 errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
